// File: icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

    // address split: tag | index | byte offset
    localparam int TAG_WIDTH    = 20;
    localparam int INDEX_WIDTH  = 8;
    localparam int OFFSET_WIDTH = 4;

    // four 32-bit words per line
    localparam int LINE_WORDS     = 4;
    localparam int WORD_SEL_WIDTH = 2;

    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [LINE_WORDS-1:0] line_t;

endpackage

`default_nettype wire

// File: icache_op_pkg.sv
`default_nettype none

package icache_op_pkg;

    // pipe request opcodes, bit 2 marks a cache op
    typedef enum logic [2:0] {
        OP_READ       = 3'd0,
        OP_CACOP_IDX0 = 3'd4,
        OP_CACOP_IDX1 = 3'd5,
        OP_CACOP_HIT  = 3'd6,
        OP_CACOP_NOP  = 3'd7
    } op_e;

    // read types on the memory port
    typedef enum logic [2:0] {
        RD_WORD = 3'd2,
        RD_LINE = 3'd4
    } rd_type_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_REFILL
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: icache_lookup_if.sv
`timescale 1ns/100ps
`default_nettype none

interface icache_lookup_if #(
    parameter int NUM_WAYS    = 2,
    parameter int TAG_WIDTH   = 20,
    parameter int INDEX_WIDTH = 8,
    parameter int LINE_BITS   = 128
);

    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // request accepted this cycle, arrays latch the set
    logic                   accept;
    logic [INDEX_WIDTH-1:0] acc_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;

    logic                   hit;
    logic [WAY_W-1:0]       hit_way;

    logic                   refill_we;
    logic [WAY_W-1:0]       refill_way;
    logic [LINE_BITS-1:0]   refill_line;

    logic                   inval_we;
    logic [WAY_W-1:0]       inval_way;

    modport ctrl (
        output accept, acc_index, lookup_tag,
        output refill_we, refill_way, refill_line,
        output inval_we, inval_way,
        input  hit, hit_way
    );

    modport tags (
        input  accept, acc_index, lookup_tag,
        input  refill_we, refill_way, inval_we, inval_way,
        output hit, hit_way
    );

    modport data (
        input accept, acc_index, hit_way,
        input refill_we, refill_way, refill_line
    );

endinterface

`default_nettype wire

// File: refill_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module refill_buffer (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   start,
    input  wire                   ret_valid,
    input  icache_cfg_pkg::word_t ret_data,
    output icache_cfg_pkg::line_t line_next
);

    localparam int SEL_W = icache_cfg_pkg::WORD_SEL_WIDTH;

    // slot for the next returned word
    logic [SEL_W-1:0]      beat_q;
    icache_cfg_pkg::line_t line_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_q <= '0;
        end else if (start) begin
            beat_q <= '0;
        end else if (ret_valid) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line_q[beat_q] <= ret_data;
        end
    end

    // merge the beat on the wire so the last word is usable at once
    always_comb begin
        line_next = line_q;
        if (ret_valid) begin
            line_next[beat_q] = ret_data;
        end
    end

endmodule

`default_nettype wire

// File: tag_valid_array.sv
`timescale 1ns/100ps
`default_nettype none

module tag_valid_array #(
    parameter int NUM_WAYS = 2
) (
    input  wire           clk,
    input  wire           resetn,
    icache_lookup_if.tags lk
);

    localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int NUM_SETS = 1 << icache_cfg_pkg::INDEX_WIDTH;

    icache_cfg_pkg::tag_t tags [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;

    // set of the request in lookup
    icache_cfg_pkg::index_t idx_q;
    icache_cfg_pkg::tag_t   preload_tag [NUM_WAYS];

    logic [NUM_WAYS-1:0] hit_vec;

    // tags are read at the accepting edge
    always_ff @(posedge clk) begin
        if (lk.accept) begin
            idx_q <= lk.acc_index;
            for (int w = 0; w < NUM_WAYS; w++) begin
                preload_tag[w] <= tags[w][lk.acc_index];
            end
        end
        if (lk.refill_we) begin
            tags[lk.refill_way][idx_q] <= lk.lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (lk.refill_we) begin
            valid_bits[lk.refill_way][idx_q] <= 1'b1;
        end else if (lk.inval_we) begin
            valid_bits[lk.inval_way][idx_q] <= 1'b0;
        end
    end

    // valid bits read live, so an invalidate is seen by the next lookup
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_bits[w][idx_q] & (preload_tag[w] == lk.lookup_tag);
        end
    end

    assign lk.hit = |hit_vec;

    always_comb begin
        lk.hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                lk.hit_way = WAY_W'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: data_way_array.sv
`timescale 1ns/100ps
`default_nettype none

module data_way_array #(
    parameter int NUM_WAYS = 2
) (
    input  wire                     clk,
    input  icache_cfg_pkg::offset_t offset_reg,
    icache_lookup_if.data           lk,
    output icache_cfg_pkg::word_t   hit_word
);

    localparam int NUM_SETS = 1 << icache_cfg_pkg::INDEX_WIDTH;
    localparam int OFS_W    = icache_cfg_pkg::OFFSET_WIDTH;
    localparam int SEL_W    = icache_cfg_pkg::WORD_SEL_WIDTH;

    icache_cfg_pkg::line_t mem [NUM_WAYS][NUM_SETS];
    icache_cfg_pkg::line_t rd_line [NUM_WAYS];
    icache_cfg_pkg::index_t idx_q;
    icache_cfg_pkg::line_t sel_line;

    // synchronous read of the whole set on accept
    always_ff @(posedge clk) begin
        if (lk.accept) begin
            idx_q <= lk.acc_index;
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_line[w] <= mem[w][lk.acc_index];
            end
        end
        if (lk.refill_we) begin
            mem[lk.refill_way][idx_q] <= lk.refill_line;
        end
    end

    // way mux then word mux
    assign sel_line = rd_line[lk.hit_way];
    assign hit_word = sel_line[offset_reg[OFS_W-1 -: SEL_W]];

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl #(
    parameter int NUM_WAYS = 2
) (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          valid,
    input  icache_op_pkg::op_e           op,
    input  icache_cfg_pkg::tag_t         tag,
    input  icache_cfg_pkg::index_t       index,
    input  icache_cfg_pkg::offset_t      offset,
    input  wire                          uncached,
    input  wire                          rd_rdy,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    input  icache_cfg_pkg::word_t        ret_data,
    input  icache_cfg_pkg::word_t        hit_word,
    input  icache_cfg_pkg::line_t        line_next,
    output logic                         addr_ok,
    output logic                         data_ok,
    output icache_cfg_pkg::word_t        rdata,
    output logic                         rd_req,
    output icache_op_pkg::rd_type_e      rd_type,
    output logic [31:0]                  rd_addr,
    output logic                         start,
    output icache_cfg_pkg::offset_t      offset_reg,
    icache_lookup_if.ctrl                lk
);

    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int OFS_W = icache_cfg_pkg::OFFSET_WIDTH;
    localparam int SEL_W = icache_cfg_pkg::WORD_SEL_WIDTH;

    icache_op_pkg::ctrl_state_e state, state_next;

    // latched request
    icache_op_pkg::op_e     op_reg;
    icache_cfg_pkg::tag_t   tag_reg;
    icache_cfg_pkg::index_t index_reg;
    logic                   uncached_reg;

    logic [WAY_W-1:0] rr_ptr;

    logic in_lookup;
    logic in_refill;
    logic is_cacop;
    logic cached_hit;
    logic ret_done;
    logic accept;

    assign in_lookup  = (state == icache_op_pkg::ST_LOOKUP);
    assign in_refill  = (state == icache_op_pkg::ST_REFILL);
    assign is_cacop   = (op_reg != icache_op_pkg::OP_READ);
    assign cached_hit = in_lookup & !is_cacop & !uncached_reg & lk.hit;
    assign ret_done   = in_refill & ret_valid & ret_last;

    // a hit or a cache op frees the lookup stage for the next request
    assign accept  = valid & ((state == icache_op_pkg::ST_IDLE)
                              | (in_lookup & (cached_hit | is_cacop)));
    assign addr_ok = accept;
    assign data_ok = cached_hit | ret_done;

    always_comb begin
        state_next = state;
        case (state)
            icache_op_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = icache_op_pkg::ST_LOOKUP;
                end
            end
            icache_op_pkg::ST_LOOKUP: begin
                if (!is_cacop && !cached_hit) begin
                    state_next = icache_op_pkg::ST_MISS;
                end else if (!accept) begin
                    state_next = icache_op_pkg::ST_IDLE;
                end
            end
            icache_op_pkg::ST_MISS: begin
                if (rd_rdy) begin
                    state_next = icache_op_pkg::ST_REFILL;
                end
            end
            default: begin
                if (ret_done) begin
                    state_next = icache_op_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= icache_op_pkg::ST_IDLE;
            rr_ptr <= '0;
        end else begin
            state <= state_next;
            if (lk.refill_we) begin
                rr_ptr <= (rr_ptr == WAY_W'(NUM_WAYS - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    // frozen from acceptance until the request retires
    always_ff @(posedge clk) begin
        if (accept) begin
            op_reg       <= op;
            tag_reg      <= tag;
            index_reg    <= index;
            offset_reg   <= offset;
            uncached_reg <= uncached;
        end
    end

    // memory read port, held steady until rd_rdy
    assign rd_req  = (state == icache_op_pkg::ST_MISS);
    assign rd_type = uncached_reg ? icache_op_pkg::RD_WORD : icache_op_pkg::RD_LINE;
    assign rd_addr = uncached_reg ? {tag_reg, index_reg, offset_reg}
                                  : {tag_reg, index_reg, {OFS_W{1'b0}}};
    assign start   = rd_req & rd_rdy;

    assign lk.accept     = accept;
    assign lk.acc_index  = index;
    assign lk.lookup_tag = tag_reg;

    // refill on the last beat, victim from the round-robin pointer
    assign lk.refill_we   = ret_done & !uncached_reg;
    assign lk.refill_way  = rr_ptr;
    assign lk.refill_line = line_next;

    // index ops take the way from the offset, hit op from the lookup
    assign lk.inval_we  = in_lookup & ((op_reg == icache_op_pkg::OP_CACOP_IDX0)
                                       | (op_reg == icache_op_pkg::OP_CACOP_IDX1)
                                       | ((op_reg == icache_op_pkg::OP_CACOP_HIT) & lk.hit));
    assign lk.inval_way = (op_reg == icache_op_pkg::OP_CACOP_HIT) ? lk.hit_way
                                                                  : offset_reg[WAY_W-1:0];

    always_comb begin
        if (in_lookup) begin
            rdata = hit_word;
        end else if (uncached_reg) begin
            rdata = ret_data;
        end else begin
            rdata = line_next[offset_reg[OFS_W-1 -: SEL_W]];
        end
    end

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top #(
    parameter int NUM_WAYS = 2
) (
    input  wire                          clk,
    input  wire                          resetn,
    // fetch pipe
    input  wire                          valid,
    input  icache_op_pkg::op_e           op,
    input  icache_cfg_pkg::tag_t         tag,
    input  icache_cfg_pkg::index_t       index,
    input  icache_cfg_pkg::offset_t      offset,
    input  wire                          uncached,
    output logic                         addr_ok,
    output logic                         data_ok,
    output icache_cfg_pkg::word_t        rdata,
    // memory read port
    output logic                         rd_req,
    output icache_op_pkg::rd_type_e      rd_type,
    output logic [31:0]                  rd_addr,
    input  wire                          rd_rdy,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    input  icache_cfg_pkg::word_t        ret_data
);

    icache_cfg_pkg::word_t   hit_word;
    icache_cfg_pkg::line_t   line_next;
    icache_cfg_pkg::offset_t offset_reg;
    logic                    start;

    icache_lookup_if #(
        .NUM_WAYS    (NUM_WAYS),
        .TAG_WIDTH   (icache_cfg_pkg::TAG_WIDTH),
        .INDEX_WIDTH (icache_cfg_pkg::INDEX_WIDTH),
        .LINE_BITS   ($bits(icache_cfg_pkg::line_t))
    ) lk ();

    icache_ctrl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .op         (op),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .uncached   (uncached),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .hit_word   (hit_word),
        .line_next  (line_next),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_type    (rd_type),
        .rd_addr    (rd_addr),
        .start      (start),
        .offset_reg (offset_reg),
        .lk         (lk.ctrl)
    );

    refill_buffer u_refill (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .line_next (line_next)
    );

    tag_valid_array #(
        .NUM_WAYS (NUM_WAYS)
    ) u_tags (
        .clk    (clk),
        .resetn (resetn),
        .lk     (lk.tags)
    );

    data_way_array #(
        .NUM_WAYS (NUM_WAYS)
    ) u_data (
        .clk        (clk),
        .offset_reg (offset_reg),
        .lk         (lk.data),
        .hit_word   (hit_word)
    );

endmodule

`default_nettype wire

// File: icache_chk.sv
`timescale 1ns/100ps
`default_nettype none

module icache_chk (
    input wire                        clk,
    input wire                        resetn,
    input icache_op_pkg::ctrl_state_e state,
    input icache_op_pkg::op_e         op,
    input wire                        rd_req,
    input wire                        rd_rdy,
    input wire [31:0]                 rd_addr,
    input wire                        addr_ok,
    input wire                        data_ok
);

    int fail_count = 0;

    // address held while memory stalls the request
    a_addr_stable: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> $stable(rd_addr))
    else begin
        fail_count++;
        $error("rd_addr changed while rd_req waited for rd_rdy");
    end

    a_no_accept_busy: assert property (@(posedge clk) disable iff (!resetn)
        (state == icache_op_pkg::ST_MISS || state == icache_op_pkg::ST_REFILL) |-> !addr_ok)
    else begin
        fail_count++;
        $error("addr_ok high during miss or refill");
    end

    // cache op accepted from the pipe, its lookup cycle stays silent
    a_cacop_silent: assert property (@(posedge clk) disable iff (!resetn)
        (addr_ok && op != icache_op_pkg::OP_READ) |=> !data_ok)
    else begin
        fail_count++;
        $error("data_ok high for a cache op");
    end

endmodule

`default_nettype wire

// File: tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache;

    localparam int WAIT_LIMIT = 60;
    localparam int STREAM_LEN = 16;

    logic                    clk;
    logic                    resetn;
    logic                    valid;
    icache_op_pkg::op_e      op;
    icache_cfg_pkg::tag_t    tag;
    icache_cfg_pkg::index_t  index;
    icache_cfg_pkg::offset_t offset;
    logic                    uncached;
    logic                    addr_ok;
    logic                    data_ok;
    icache_cfg_pkg::word_t   rdata;
    logic                    rd_req;
    icache_op_pkg::rd_type_e rd_type;
    logic [31:0]             rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    icache_cfg_pkg::word_t   ret_data;

    // what the memory model saw on its last granted request
    int                      rd_count;
    logic [31:0]             last_addr;
    icache_op_pkg::rd_type_e last_type;

    int    errors;
    int    test_err;
    int    tests_run;
    int    tests_failed;
    string cur_test;

    icache_top #(
        .NUM_WAYS (2)
    ) u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .uncached  (uncached),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    bind icache_ctrl icache_chk u_chk (
        .clk     (clk),
        .resetn  (resetn),
        .state   (state),
        .op      (op),
        .rd_req  (rd_req),
        .rd_rdy  (rd_rdy),
        .rd_addr (rd_addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (6 * 400) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", 6 * 400);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] t, input logic [7:0] i,
                                              input logic [3:0] o);
        return {t, i, o};
    endfunction

    // grant after 0..3 cycles, then beats with gaps of 0..2 cycles
    initial begin : mem_model
        int delay;
        int beats;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rd_count  = 0;
        last_addr = '0;
        last_type = icache_op_pkg::RD_WORD;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                rd_rdy    = 1'b1;
                last_addr = rd_addr;
                last_type = rd_type;
                rd_count++;
                @(negedge clk);
                rd_rdy = 1'b0;
                beats  = (last_type == icache_op_pkg::RD_LINE) ? 4 : 1;
                for (int b = 0; b < beats; b++) begin
                    repeat ($urandom_range(2, 0)) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (b == beats - 1);
                    ret_data  = mem_word(last_addr + 32'(4 * b));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s/%s: expected %h, actual %h", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err = 0;
        resetn   = 1'b0;
        valid    = 1'b0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
    endtask

    task automatic report_test();
        tests_run++;
        errors += test_err;
        if (test_err == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", cur_test, test_err);
        end
    endtask

    task automatic drive_addr(input logic [31:0] a);
        tag    = a[31:12];
        index  = a[11:4];
        offset = a[3:0];
    endtask

    // starts at a falling edge, returns at the falling edge of the lookup cycle
    task automatic send_req(input icache_op_pkg::op_e o, input logic [31:0] a,
                            input logic unc);
        int n;
        n        = 0;
        valid    = 1'b1;
        op       = o;
        uncached = unc;
        drive_addr(a);
        #2;
        while (!addr_ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (!addr_ok) begin
            $display("%s: request for %h was never accepted", cur_test, a);
            test_err++;
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic read_check(input string what, input logic [31:0] a, input logic unc,
                              input int exp_reqs);
        int c0;
        int lat;
        c0 = rd_count;
        send_req(icache_op_pkg::OP_READ, a, unc);
        lat = 1;
        #2;
        while (!data_ok && lat < WAIT_LIMIT) begin
            @(negedge clk);
            #2;
            lat++;
        end
        if (!data_ok) begin
            $display("%s/%s: no data_ok within %0d cycles", cur_test, what, WAIT_LIMIT);
            test_err++;
        end else begin
            check_val({what, " rdata"}, mem_word(a), rdata);
        end
        @(negedge clk);
        check_val({what, " rd_req count"}, 32'(exp_reqs), 32'(rd_count - c0));
        // a hit answers in the lookup cycle
        if (exp_reqs == 0) begin
            check_val({what, " hit latency"}, 1, 32'(lat));
        end
    endtask

    task automatic issue_cacop(input string what, input icache_op_pkg::op_e o,
                               input logic [31:0] a);
        send_req(o, a, 1'b0);
        #2;
        check_val({what, " data_ok"}, 0, 32'(data_ok));
        @(negedge clk);
    endtask

    task automatic test_reset();
        start_test("reset");
        #2;
        check_val("addr_ok", 0, 32'(addr_ok));
        check_val("data_ok", 0, 32'(data_ok));
        check_val("rd_req", 0, 32'(rd_req));
        @(negedge clk);
        report_test();
    endtask

    task automatic test_miss_hit();
        logic [31:0] a;
        a = make_addr(20'h00012, 8'h34, 4'h8);
        start_test("miss_hit");
        read_check("first", a, 1'b0, 1);
        check_val("rd_addr", {a[31:4], 4'h0}, last_addr);
        check_val("rd_type", 32'(icache_op_pkg::RD_LINE), 32'(last_type));
        read_check("same line", a ^ 32'h4, 1'b0, 0);
        report_test();
    endtask

    task automatic test_replace();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = make_addr(20'h00100, 8'h5a, 4'h0);
        b = make_addr(20'h00200, 8'h5a, 4'h4);
        c = make_addr(20'h00300, 8'h5a, 4'h8);
        start_test("replace");
        read_check("A fill", a, 1'b0, 1);
        read_check("B fill", b, 1'b0, 1);
        read_check("A hit", a, 1'b0, 0);
        read_check("B hit", b, 1'b0, 0);
        // pointer wrapped, so C lands in way 0
        read_check("C fill", c, 1'b0, 1);
        read_check("B kept", b, 1'b0, 0);
        read_check("A evicted", a, 1'b0, 1);
        report_test();
    endtask

    task automatic test_uncached();
        logic [31:0] u;
        u = make_addr(20'h00400, 8'h11, 4'h4);
        start_test("uncached");
        read_check("uncached", u, 1'b1, 1);
        check_val("word rd_addr", u, last_addr);
        check_val("word rd_type", 32'(icache_op_pkg::RD_WORD), 32'(last_type));
        read_check("uncached again", u, 1'b1, 1);
        read_check("cached after", u, 1'b0, 1);
        check_val("line rd_type", 32'(icache_op_pkg::RD_LINE), 32'(last_type));
        report_test();
    endtask

    task automatic test_cacop();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] h;
        logic [31:0] n;
        w0 = make_addr(20'h00500, 8'h22, 4'h0);
        w1 = make_addr(20'h00600, 8'h22, 4'h4);
        h  = make_addr(20'h00abc, 8'h33, 4'h8);
        n  = make_addr(20'h00def, 8'h44, 4'hc);
        start_test("cacop");
        read_check("way0 fill", w0, 1'b0, 1);
        read_check("way1 fill", w1, 1'b0, 1);
        // offset bit 0 picks way 1
        issue_cacop("idx1", icache_op_pkg::OP_CACOP_IDX1, make_addr(20'h0, 8'h22, 4'h1));
        read_check("way0 kept", w0, 1'b0, 0);
        read_check("way1 gone", w1, 1'b0, 1);
        read_check("hit fill", h, 1'b0, 1);
        issue_cacop("hit inval", icache_op_pkg::OP_CACOP_HIT, h);
        read_check("hit gone", h, 1'b0, 1);
        read_check("nop fill", n, 1'b0, 1);
        issue_cacop("nop", icache_op_pkg::OP_CACOP_NOP, n);
        read_check("nop kept", n, 1'b0, 0);
        report_test();
    endtask

    task automatic test_b2b();
        logic [31:0] lines [4];
        logic [31:0] addrs [STREAM_LEN];
        logic [31:0] exp_q [$];
        int          pick;
        int          i;
        int          got;
        int          cyc;
        int          c0;
        logic        acc;
        start_test("back_to_back");
        // two sets, both ways of each filled
        for (int k = 0; k < 4; k++) begin
            lines[k] = make_addr(20'h00700 + 20'(k), 8'(8'h60 + k / 2), 4'h0);
            read_check("preload", lines[k], 1'b0, 1);
        end
        for (int k = 0; k < STREAM_LEN; k++) begin
            pick     = $urandom_range(3, 0);
            addrs[k] = lines[pick] | ($urandom_range(3, 0) << 2);
        end
        c0       = rd_count;
        i        = 0;
        got      = 0;
        cyc      = 0;
        op       = icache_op_pkg::OP_READ;
        uncached = 1'b0;
        valid    = 1'b1;
        drive_addr(addrs[0]);
        while (got < STREAM_LEN && cyc < WAIT_LIMIT) begin
            #2;
            if (data_ok) begin
                if (exp_q.size() == 0) begin
                    $display("%s: data_ok with no read outstanding", cur_test);
                    test_err++;
                end else begin
                    check_val("stream rdata", exp_q.pop_front(), rdata);
                end
                got++;
            end
            acc = valid & addr_ok;
            @(negedge clk);
            cyc++;
            if (acc) begin
                exp_q.push_back(mem_word(addrs[i]));
                i++;
                if (i < STREAM_LEN) begin
                    drive_addr(addrs[i]);
                end else begin
                    valid = 1'b0;
                end
            end
        end
        valid = 1'b0;
        if (got < STREAM_LEN) begin
            $display("%s: only %0d of %0d reads answered", cur_test, got, STREAM_LEN);
            test_err++;
        end
        check_val("stream rd_req count", 0, 32'(rd_count - c0));
        report_test();
    endtask

    initial begin
        int seed;
        seed         = $urandom(32'h49fa);
        resetn       = 1'b0;
        valid        = 1'b0;
        op           = icache_op_pkg::OP_READ;
        tag          = '0;
        index        = '0;
        offset       = '0;
        uncached     = 1'b0;
        errors       = 0;
        test_err     = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_reset();
        test_miss_hit();
        test_replace();
        test_uncached();
        test_cacop();
        test_b2b();
        errors += u_dut.u_ctrl.u_chk.fail_count;
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
icache_cfg_pkg.sv
icache_op_pkg.sv
icache_lookup_if.sv
refill_buffer.sv
tag_valid_array.sv
data_way_array.sv
icache_ctrl.sv
icache_top.sv
icache_chk.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_icache -f project.f -o sim_icache
out=$(./obj_dir/sim_icache)
echo "$out"
if echo "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
